// ==== list.f ====
+incdir+verilog
verilog/rename_pkg.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/rename.sv
verilog/rename_top.sv
verif/tb_clock.sv
verif/rename_tb.sv

// ==== verif/rename_tb.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_tb
	import rename_pkg::*;
();

	localparam int RAND_GROUPS = 200;
	// every group takes at most a few cycles, plus the directed tests
	localparam int CYCLE_LIMIT = 4*RAND_GROUPS + 600;

	logic        clk;
	logic        rst_n;
	logic        en;
	arch_group_t grp;
	logic        save_en;
	lane_mask_t  save_mask;
	logic        ret;
	lane_mask_t  free_en;
	preg_group_t free_prd;
	logic        o_valid;
	phys_group_t o_group;
	preg_group_t o_old;
	logic        o_stall;

	// next inputs, applied on the falling edge
	logic        nx_en;
	arch_group_t nx_grp;
	logic        nx_save_en;
	lane_mask_t  nx_save_mask;
	logic        nx_ret;
	lane_mask_t  nx_free_en;
	preg_group_t nx_free_prd;

	// reference model
	preg_t       map_m  [`RN_NUM_AREG];
	preg_t       ckpt_m [`RN_NUM_AREG];
	preg_t       fl_m   [`RN_NUM_PREG];
	int          head_m;
	int          tail_m;
	int          save_head_m;
	bit          busy_m;
	bit          s1_v;
	bit          out_v;
	phys_group_t s1_g;
	phys_group_t out_g;
	preg_group_t s1_o;
	preg_group_t out_o;
	preg_t       retire_q [$];
	bit          collect;

	int          errors;
	int          test_base;
	int          tests_run;
	int          cycles;
	integer      seed;

	tb_clock u_clock (.o_clk(clk));

	rename_top dut0 (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_en       (en),
		.i_group    (grp),
		.i_save_en  (save_en),
		.i_save_mask(save_mask),
		.i_return   (ret),
		.i_free_en  (free_en),
		.i_free_prd (free_prd),
		.o_valid    (o_valid),
		.o_group    (o_group),
		.o_old      (o_old),
		.o_stall    (o_stall)
	);

	task automatic show_mismatch(string name, logic [127:0] exp, logic [127:0] got);
		$display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
		errors++;
	endtask

	task automatic report_problem(string msg);
		$display("error at %0t: %s", $time, msg);
		errors++;
	endtask

	function automatic int high_lane(lane_mask_t m);
		int r;
		r = -1;
		for (int k = 0; k < `RN_LANES; k++) begin
			if (m[k])
				r = k;
		end
		return r;
	endfunction

	task automatic set_idle();
		nx_en = 1'b0;
		nx_grp = '0;
		nx_save_en = 1'b0;
		nx_save_mask = '0;
		nx_ret = 1'b0;
		nx_free_en = '0;
		nx_free_prd = '0;
	endtask

	task automatic random_group(bit all_nz);
		for (int k = 0; k < `RN_LANES; k++) begin
			nx_grp[k].rd  = areg_t'($random(seed));
			nx_grp[k].rs1 = areg_t'($random(seed));
			nx_grp[k].rs2 = areg_t'($random(seed));
			if (all_nz && nx_grp[k].rd == '0)
				nx_grp[k].rd = areg_t'(k + 1);
		end
	endtask

	task automatic queue_frees(int n);
		nx_free_en = '0;
		for (int k = 0; k < `RN_LANES; k++) begin
			if (k < n && retire_q.size() > 0) begin
				nx_free_en[k] = 1'b1;
				nx_free_prd[k] = retire_q.pop_front();
			end
		end
	endtask

	// one clock: check outputs, drive inputs, advance the model
	task automatic step(output bit acc);
		int          need;
		bit          stall_m;
		phys_group_t g;
		preg_group_t o;
		@(negedge clk);
		assert (o_valid === out_v) else show_mismatch("o_valid", out_v, o_valid);
		if (out_v) begin
			assert (o_group === out_g) else show_mismatch("o_group", out_g, o_group);
			assert (o_old === out_o) else show_mismatch("o_old", out_o, o_old);
		end
		en = nx_en;
		grp = nx_grp;
		save_en = nx_save_en;
		save_mask = nx_save_mask;
		ret = nx_ret;
		free_en = nx_free_en;
		free_prd = nx_free_prd;
		need = 0;
		for (int k = 0; k < `RN_LANES; k++) begin
			if (nx_grp[k].rd != '0)
				need++;
		end
		stall_m = nx_ret || busy_m || ((tail_m - head_m) < need);
		#1;
		assert (o_stall === stall_m) else show_mismatch("o_stall", stall_m, o_stall);
		acc = nx_en && !stall_m;
		out_v = s1_v && !nx_ret;
		out_g = s1_g;
		out_o = s1_o;
		s1_v = acc;
		if (acc) begin
			for (int k = 0; k < `RN_LANES; k++) begin
				g[k].prs1 = map_m[nx_grp[k].rs1];
				g[k].prs2 = map_m[nx_grp[k].rs2];
				o[k] = map_m[nx_grp[k].rd];
				if (nx_grp[k].rd != '0) begin
					g[k].prd = fl_m[head_m % `RN_NUM_PREG];
					head_m++;
					map_m[nx_grp[k].rd] = g[k].prd;
					if (collect)
						retire_q.push_back(o[k]);
				end else begin
					g[k].prd = '0;
				end
				if (nx_save_en && k == high_lane(nx_save_mask)) begin
					ckpt_m = map_m;
					save_head_m = head_m;
				end
			end
			s1_g = g;
			s1_o = o;
		end
		if (nx_ret && !busy_m) begin
			map_m = ckpt_m;
			head_m = save_head_m;
		end
		busy_m = nx_ret && !busy_m;
		for (int k = 0; k < `RN_LANES; k++) begin
			if (nx_free_en[k]) begin
				fl_m[tail_m % `RN_NUM_PREG] = nx_free_prd[k];
				tail_m++;
			end
		end
	endtask

	task automatic drain();
		bit acc;
		set_idle();
		repeat (3) step(acc);
	endtask

	task automatic finish_test(string name);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - test_base);
		test_base = errors;
	endtask

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		bit acc;
		int done;
		seed = 32'hc209;
		errors = 0;
		test_base = 0;
		tests_run = 0;
		cycles = 0;
		collect = 1'b1;
		rst_n = 1'b0;
		en = 1'b0;
		grp = '0;
		save_en = 1'b0;
		save_mask = '0;
		ret = 1'b0;
		free_en = '0;
		free_prd = '0;
		set_idle();
		for (int a = 0; a < `RN_NUM_AREG; a++) begin
			map_m[a] = preg_t'(a);
			ckpt_m[a] = preg_t'(a);
		end
		for (int i = 0; i < `RN_NUM_PREG; i++) begin
			fl_m[i] = preg_t'(i + `RN_NUM_PREG - `RN_FREE_INIT);
		end
		head_m = 0;
		save_head_m = 0;
		tail_m = `RN_FREE_INIT;
		busy_m = 1'b0;
		s1_v = 1'b0;
		out_v = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// distinct destinations after reset
		step(acc);
		nx_en = 1'b1;
		for (int k = 0; k < `RN_LANES; k++) begin
			nx_grp[k].rd = areg_t'(k + 1);
			nx_grp[k].rs1 = areg_t'(10 + 2*k);
			nx_grp[k].rs2 = areg_t'(11 + 2*k);
		end
		step(acc);
		set_idle();
		step(acc);
		step(acc);
		for (int k = 0; k < `RN_LANES; k++) begin
			assert (o_group[k].prd == preg_t'(32 + k))
				else show_mismatch("o_group.prd", 32 + k, o_group[k].prd);
			assert (o_group[k].prs1 == preg_t'(10 + 2*k))
				else show_mismatch("o_group.prs1", 10 + 2*k, o_group[k].prs1);
			assert (o_old[k] == preg_t'(k + 1)) else show_mismatch("o_old", k + 1, o_old[k]);
		end
		drain();
		finish_test("reset and distinct destinations");

		// dependencies inside one group
		nx_en = 1'b1;
		nx_grp[0] = '{rd: 5'd5, rs2: 5'd2, rs1: 5'd1};
		nx_grp[1] = '{rd: 5'd6, rs2: 5'd3, rs1: 5'd5};
		nx_grp[2] = '{rd: 5'd5, rs2: 5'd6, rs1: 5'd4};
		nx_grp[3] = '{rd: 5'd7, rs2: 5'd6, rs1: 5'd5};
		step(acc);
		nx_grp[0] = '{rd: 5'd8, rs2: 5'd6, rs1: 5'd5};
		nx_grp[1] = '0;
		nx_grp[2] = '0;
		nx_grp[3] = '0;
		step(acc);
		drain();
		finish_test("in-group dependencies");

		// destination x0
		nx_en = 1'b1;
		nx_grp[0] = '{rd: 5'd0, rs2: 5'd0, rs1: 5'd5};
		nx_grp[1] = '{rd: 5'd9, rs2: 5'd0, rs1: 5'd0};
		nx_grp[2] = '{rd: 5'd0, rs2: 5'd9, rs1: 5'd9};
		nx_grp[3] = '{rd: 5'd10, rs2: 5'd0, rs1: 5'd0};
		step(acc);
		random_group(1'b1);
		step(acc);
		drain();
		finish_test("zero destination");

		// exhaust the free list, then refill it
		while ((tail_m - head_m) >= `RN_LANES) begin
			nx_en = 1'b1;
			random_group(1'b1);
			acc = 1'b0;
			while (!acc)
				step(acc);
		end
		set_idle();
		nx_en = 1'b1;
		random_group(1'b1);
		repeat (3) begin
			step(acc);
			assert (o_stall) else report_problem("stage did not stall with the free list empty");
		end
		queue_frees(4);
		step(acc);
		nx_free_en = '0;
		acc = 1'b0;
		while (!acc)
			step(acc);
		random_group(1'b1);
		step(acc);
		drain();
		finish_test("free list empty and refill");

		// checkpoint and return
		collect = 1'b0;
		repeat (4) begin
			queue_frees(4);
			step(acc);
		end
		set_idle();
		nx_en = 1'b1;
		random_group(1'b0);
		nx_save_en = 1'b1;
		nx_save_mask = 4'b0100;
		acc = 1'b0;
		while (!acc)
			step(acc);
		nx_save_en = 1'b0;
		nx_save_mask = '0;
		repeat (3) begin
			random_group(1'b0);
			step(acc);
		end
		random_group(1'b0);
		nx_ret = 1'b1;
		step(acc);
		nx_ret = 1'b0;
		step(acc);
		assert (o_stall) else report_problem("stage did not stall during the restore cycle");
		repeat (3) begin
			random_group(1'b0);
			step(acc);
		end
		drain();
		finish_test("checkpoint and return");

		// random traffic
		collect = 1'b1;
		done = 0;
		while (done < RAND_GROUPS) begin
			nx_en = 1'b1;
			random_group(1'b0);
			queue_frees($random(seed) & 32'h7);
			step(acc);
			if (acc)
				done++;
		end
		drain();
		finish_test("random groups");

		$display("tests run %0d, failed checks %0d", tests_run, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk
);

	// 20 ns period
	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk;
	end

endmodule

// ==== verilog/rename_top.sv ====
`timescale 1ns/1ps

module rename_top
	import rename_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_en,
	input  arch_group_t i_group,
	input  logic        i_save_en,
	input  lane_mask_t  i_save_mask,
	input  logic        i_return,
	input  lane_mask_t  i_free_en,
	input  preg_group_t i_free_prd,
	output logic        o_valid,
	output phys_group_t o_group,
	output preg_group_t o_old,
	output logic        o_stall
);

	preg_group_t head_prd;
	logic [7:0]  count;
	lane_mask_t  pop;
	logic        ckpt_save;
	logic [1:0]  ckpt_lane;
	logic        ckpt_return;

	rename u_rename (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_en         (i_en),
		.i_group      (i_group),
		.i_save_en    (i_save_en),
		.i_save_mask  (i_save_mask),
		.i_return     (i_return),
		.i_head_prd   (head_prd),
		.i_count      (count),
		.o_pop        (pop),
		.o_ckpt_save  (ckpt_save),
		.o_ckpt_lane  (ckpt_lane),
		.o_ckpt_return(ckpt_return),
		.o_stall      (o_stall),
		.o_valid      (o_valid),
		.o_group      (o_group),
		.o_old        (o_old)
	);

	// commit frees go straight into the queue tail
	free_list u_free_list (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_pop      (pop),
		.i_push     (i_free_en),
		.i_push_prd (i_free_prd),
		.i_save_en  (ckpt_save),
		.i_save_lane(ckpt_lane),
		.i_return   (ckpt_return),
		.o_head_prd (head_prd),
		.o_count    (count)
	);

endmodule

// ==== verilog/rename.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename
	import rename_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_en,
	input  arch_group_t i_group,
	input  logic        i_save_en,
	input  lane_mask_t  i_save_mask,
	input  logic        i_return,
	input  preg_group_t i_head_prd,
	input  logic [7:0]  i_count,
	output lane_mask_t  o_pop,
	output logic        o_ckpt_save,
	output logic [1:0]  o_ckpt_lane,
	output logic        o_ckpt_return,
	output logic        o_stall,
	output logic        o_valid,
	output phys_group_t o_group,
	output preg_group_t o_old
);

	lane_mask_t              rd_nz;
	logic [7:0]              need;
	logic                    busy;
	logic                    accept;
	preg_group_t             new_prd;
	areg_t [3*`RN_LANES-1:0] raddr;
	preg_t [3*`RN_LANES-1:0] rdata;
	areg_t [`RN_LANES-1:0]   waddr;
	lane_mask_t              hit_rs1 [`RN_LANES];
	lane_mask_t              hit_rs2 [`RN_LANES];
	lane_mask_t              hit_rd  [`RN_LANES];

	logic                    s1_valid;
	preg_t [3*`RN_LANES-1:0] s1_rdata;
	preg_group_t             s1_prd;
	lane_mask_t              s1_hit_rs1 [`RN_LANES];
	lane_mask_t              s1_hit_rs2 [`RN_LANES];
	lane_mask_t              s1_hit_rd  [`RN_LANES];
	phys_group_t             s2_group;
	preg_group_t             s2_old;

	// nearest earlier writer wins
	function automatic preg_t pick(preg_t base, lane_mask_t hit, preg_group_t prd);
		preg_t r;
		r = base;
		for (int j = 0; j < `RN_LANES; j++) begin
			if (hit[j])
				r = prd[j];
		end
		return r;
	endfunction

	always_comb begin
		need = '0;
		o_ckpt_lane = '0;
		for (int k = 0; k < `RN_LANES; k++) begin
			rd_nz[k]       = (i_group[k].rd != '0);
			need           = need + rd_nz[k];
			new_prd[k]     = rd_nz[k] ? i_head_prd[k] : '0;
			waddr[k]       = i_group[k].rd;
			raddr[3*k]     = i_group[k].rs1;
			raddr[3*k + 1] = i_group[k].rs2;
			raddr[3*k + 2] = i_group[k].rd;
			if (i_save_mask[k])
				o_ckpt_lane = 2'(k);
		end
	end

	// comparator triangle, x0 never counts as a writer
	always_comb begin
		for (int k = 0; k < `RN_LANES; k++) begin
			hit_rs1[k] = '0;
			hit_rs2[k] = '0;
			hit_rd[k]  = '0;
			for (int j = 0; j < k; j++) begin
				hit_rs1[k][j] = rd_nz[j] && (i_group[k].rs1 == i_group[j].rd);
				hit_rs2[k][j] = rd_nz[j] && (i_group[k].rs2 == i_group[j].rd);
				hit_rd[k][j]  = rd_nz[j] && (i_group[k].rd == i_group[j].rd);
			end
		end
	end

	// a return owns the stage for its edge
	assign o_stall       = i_return | busy | (i_count < need);
	assign accept        = i_en & ~o_stall;
	assign o_pop         = {`RN_LANES{accept}} & rd_nz;
	assign o_ckpt_save   = accept & i_save_en & (|i_save_mask);
	assign o_ckpt_return = i_return;

	map_table u_map (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_raddr    (raddr),
		.i_we       (o_pop),
		.i_waddr    (waddr),
		.i_wdata    (new_prd),
		.i_save_en  (o_ckpt_save),
		.i_save_lane(o_ckpt_lane),
		.i_return   (i_return),
		.o_rdata    (rdata),
		.o_busy     (busy)
	);

	always_ff @(posedge i_clk) begin
		if (accept) begin
			s1_rdata   <= rdata;
			s1_prd     <= new_prd;
			s1_hit_rs1 <= hit_rs1;
			s1_hit_rs2 <= hit_rs2;
			s1_hit_rd  <= hit_rd;
		end
	end

	always_comb begin
		for (int k = 0; k < `RN_LANES; k++) begin
			s2_group[k].prd  = s1_prd[k];
			s2_group[k].prs1 = pick(s1_rdata[3*k], s1_hit_rs1[k], s1_prd);
			s2_group[k].prs2 = pick(s1_rdata[3*k + 1], s1_hit_rs2[k], s1_prd);
			s2_old[k]        = pick(s1_rdata[3*k + 2], s1_hit_rd[k], s1_prd);
		end
	end

	always_ff @(posedge i_clk) begin
		if (s1_valid) begin
			o_group <= s2_group;
			o_old   <= s2_old;
		end
	end

	// return flushes whatever sits in stage 1
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
			o_valid  <= 1'b0;
		end else begin
			s1_valid <= accept;
			o_valid  <= s1_valid & ~i_return;
		end
	end

endmodule

// ==== verilog/free_list.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module free_list
	import rename_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  lane_mask_t  i_pop,
	input  lane_mask_t  i_push,
	input  preg_group_t i_push_prd,
	input  logic        i_save_en,
	input  logic [1:0]  i_save_lane,
	input  logic        i_return,
	output preg_group_t o_head_prd,
	output logic [7:0]  o_count
);

	preg_t mem [`RN_NUM_PREG];

	// pointers carry one wrap bit above the index
	logic [`RN_PREG_W:0] head_q;
	logic [`RN_PREG_W:0] tail_q;
	logic [`RN_PREG_W:0] save_head_q;
	logic [`RN_PREG_W:0] pop_cnt;
	logic [`RN_PREG_W:0] push_cnt;
	logic [`RN_PREG_W:0] save_cnt;
	logic [`RN_PREG_W:0] rd_ptr [`RN_LANES];
	logic [`RN_PREG_W:0] wr_ptr [`RN_LANES];

	always_comb begin
		pop_cnt  = '0;
		push_cnt = '0;
		save_cnt = '0;
		for (int k = 0; k < `RN_LANES; k++) begin
			rd_ptr[k] = head_q + pop_cnt;
			wr_ptr[k] = tail_q + push_cnt;
			pop_cnt   = pop_cnt + i_pop[k];
			push_cnt  = push_cnt + i_push[k];
			if (k == int'(i_save_lane))
				save_cnt = pop_cnt;
		end
	end

	// k-th popping lane gets the k-th queued entry
	always_comb begin
		for (int k = 0; k < `RN_LANES; k++) begin
			o_head_prd[k] = mem[rd_ptr[k][`RN_PREG_W-1:0]];
		end
	end

	assign o_count = tail_q - head_q;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			head_q      <= '0;
			save_head_q <= '0;
			tail_q      <= (`RN_PREG_W+1)'(`RN_FREE_INIT);
			for (int i = 0; i < `RN_NUM_PREG; i++) begin
				mem[i] <= preg_t'(i + `RN_NUM_PREG - `RN_FREE_INIT);
			end
		end else begin
			for (int k = 0; k < `RN_LANES; k++) begin
				if (i_push[k])
					mem[wr_ptr[k][`RN_PREG_W-1:0]] <= i_push_prd[k];
			end
			tail_q <= tail_q + push_cnt;
			if (i_return)
				head_q <= save_head_q;
			else
				head_q <= head_q + pop_cnt;
			if (i_save_en)
				save_head_q <= head_q + save_cnt;
		end
	end

endmodule

// ==== verilog/map_table.sv ====
`timescale 1ns/1ps
`include "rename_macros.svh"

module map_table
	import rename_pkg::*;
(
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  areg_t [3*`RN_LANES-1:0] i_raddr,
	input  lane_mask_t              i_we,
	input  areg_t [`RN_LANES-1:0]   i_waddr,
	input  preg_group_t             i_wdata,
	input  logic                    i_save_en,
	input  logic [1:0]              i_save_lane,
	input  logic                    i_return,
	output preg_t [3*`RN_LANES-1:0] o_rdata,
	output logic                    o_busy
);

	preg_t     table_q [`RN_NUM_AREG];
	preg_t     table_d [`RN_NUM_AREG];
	preg_t     ckpt_q  [`RN_NUM_AREG];
	preg_t     ckpt_d  [`RN_NUM_AREG];
	mt_state_t state_q;

	// reads see the table before this cycle's writes
	always_comb begin
		for (int i = 0; i < 3*`RN_LANES; i++) begin
			o_rdata[i] = table_q[i_raddr[i]];
		end
	end

	// lane order, so the last writer of a register wins
	always_comb begin
		table_d = table_q;
		ckpt_d  = ckpt_q;
		for (int k = 0; k < `RN_LANES; k++) begin
			if (i_we[k])
				table_d[i_waddr[k]] = i_wdata[k];
			// snapshot once the save lane has written
			if (k == int'(i_save_lane))
				ckpt_d = table_d;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_q <= MT_RUN;
			for (int a = 0; a < `RN_NUM_AREG; a++) begin
				table_q[a] <= preg_t'(a);
				ckpt_q[a]  <= preg_t'(a);
			end
		end else begin
			case (state_q)
				MT_RUN: begin
					table_q <= table_d;
					if (i_save_en)
						ckpt_q <= ckpt_d;
					if (i_return)
						state_q <= MT_RESTORE;
				end
				MT_RESTORE: begin
					table_q <= ckpt_q;
					state_q <= MT_RUN;
				end
				default: begin
					state_q <= MT_RUN;
				end
			endcase
		end
	end

	assign o_busy = (state_q == MT_RESTORE);

endmodule

// ==== verilog/rename_pkg.sv ====
`include "rename_macros.svh"

package rename_pkg;

	typedef logic [`RN_AREG_W-1:0] areg_t;
	typedef logic [`RN_PREG_W-1:0] preg_t;
	typedef logic [`RN_LANES-1:0]  lane_mask_t;

	// same field order as the decoded slot { rd, rs2, rs1 }
	typedef struct packed {
		areg_t rd;
		areg_t rs2;
		areg_t rs1;
	} arch_slot_t;

	typedef struct packed {
		preg_t prd;
		preg_t prs2;
		preg_t prs1;
	} phys_slot_t;

	typedef arch_slot_t [`RN_LANES-1:0] arch_group_t;
	typedef phys_slot_t [`RN_LANES-1:0] phys_group_t;
	typedef preg_t      [`RN_LANES-1:0] preg_group_t;

	typedef enum logic {
		MT_RUN,
		MT_RESTORE
	} mt_state_t;

endpackage

// ==== verilog/rename_macros.svh ====
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// instructions renamed per cycle
`define RN_LANES 4

`define RN_AREG_W 5
`define RN_PREG_W 7
`define RN_NUM_PREG 128
`define RN_NUM_AREG 32

// x0..x31 start mapped onto p0..p31, the rest are free
`define RN_FREE_INIT 96

`endif
